//--- sim.f
hdl/cpu_pkg.sv
hdl/cpu_ctrl_if.sv
hdl/cpu_decoder.sv
hdl/cpu_alu.sv
hdl/cpu_sequencer.sv
hdl/cpu_datapath.sv
hdl/cpu_top.sv
testbench/tb_clock.sv
testbench/tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_cpu
FILELIST  := sim.f
OBJ_DIR   := obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_cpu.sv
// One fixed-seed program at 0x0400, linear flow only; final flags are read from the datapath P reg
`timescale 1ns/1ps

module tb_cpu;

  localparam int             N_RANDOM  = 300;
  localparam int             HOLD_CYC  = 20;
  localparam cpu_pkg::addr_t PROG_BASE = 16'h0400;
  localparam cpu_pkg::data_t BAD_OP    = 8'h02;

  logic           clk;
  logic           resetn;
  cpu_pkg::data_t rd_data;
  cpu_pkg::addr_t address;
  cpu_pkg::data_t wr_data;
  logic           wr_enable;

  // 64 KiB, asynchronous read
  cpu_pkg::data_t mem [0:65535];

  cpu_pkg::opcode_e op_table [19] = '{
    cpu_pkg::OP_CLC, cpu_pkg::OP_SEC, cpu_pkg::OP_CLV, cpu_pkg::OP_NOP,
    cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDX_IMM, cpu_pkg::OP_LDY_IMM,
    cpu_pkg::OP_LDA_ABS, cpu_pkg::OP_LDX_ABS, cpu_pkg::OP_LDY_ABS,
    cpu_pkg::OP_STA_ABS, cpu_pkg::OP_STX_ABS, cpu_pkg::OP_STY_ABS,
    cpu_pkg::OP_ADC_ABS, cpu_pkg::OP_SBC_ABS, cpu_pkg::OP_AND_ABS,
    cpu_pkg::OP_ORA_ABS, cpu_pkg::OP_EOR_ABS, cpu_pkg::OP_JMP_ABS
  };

  // Reference model state and expected bus events
  cpu_pkg::data_t m_a = 8'h00;
  cpu_pkg::data_t m_x = 8'h00;
  cpu_pkg::data_t m_y = 8'h00;
  cpu_pkg::data_t m_p = cpu_pkg::P_RESET;
  cpu_pkg::addr_t pc_build;
  cpu_pkg::addr_t bad_pc;
  int             cyc_build;
  int             halt_cyc;
  int             n_instr = 0;

  cpu_pkg::addr_t fetch_addr_q [$];
  int             fetch_cyc_q [$];
  cpu_pkg::addr_t wr_addr_q [$];
  cpu_pkg::data_t wr_data_q [$];
  int             wr_cyc_q [$];

  int   fetch_errs = 0;
  int   write_errs = 0;
  int   flag_errs  = 0;
  int   other_errs = 0;
  int   cyc        = 0;
  int   limit      = 0;
  int   fi         = 0;
  int   wi         = 0;
  logic done       = 1'b0;
  logic timed_out  = 1'b0;

  tb_clock tb_clock_inst (
    .clk    (clk),
    .resetn (resetn)
  );

  cpu_top cpu_top_inst (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable)
  );

  assign rd_data = mem[address];

  always @(posedge clk) begin
    if (wr_enable) begin
      mem[address] <= wr_data;
    end
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  task automatic set_nz(input cpu_pkg::data_t v);
    m_p[cpu_pkg::STAT_N] = v[7];
    m_p[cpu_pkg::STAT_Z] = (v == 8'h00);
  endtask

  task automatic expect_write(input cpu_pkg::addr_t a, input cpu_pkg::data_t d);
    wr_addr_q.push_back(a);
    wr_data_q.push_back(d);
    wr_cyc_q.push_back(cyc_build + 3);
  endtask

  task automatic model_exec(input cpu_pkg::opcode_e op, input cpu_pkg::addr_t ea);
    cpu_pkg::data_t val;
    cpu_pkg::data_t b;
    int             u_sum;
    int             s_sum;
    val = (op inside {cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDX_IMM, cpu_pkg::OP_LDY_IMM}) ?
          ea[7:0] : mem[ea];
    fetch_addr_q.push_back(pc_build);
    fetch_cyc_q.push_back(cyc_build);
    case (op)
      cpu_pkg::OP_CLC: m_p[cpu_pkg::STAT_C] = 1'b0;
      cpu_pkg::OP_SEC: m_p[cpu_pkg::STAT_C] = 1'b1;
      cpu_pkg::OP_CLV: m_p[cpu_pkg::STAT_V] = 1'b0;
      cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDA_ABS: begin
        m_a = val;
        set_nz(m_a);
      end
      cpu_pkg::OP_LDX_IMM, cpu_pkg::OP_LDX_ABS: begin
        m_x = val;
        set_nz(m_x);
      end
      cpu_pkg::OP_LDY_IMM, cpu_pkg::OP_LDY_ABS: begin
        m_y = val;
        set_nz(m_y);
      end
      cpu_pkg::OP_STA_ABS: expect_write(ea, m_a);
      cpu_pkg::OP_STX_ABS: expect_write(ea, m_x);
      cpu_pkg::OP_STY_ABS: expect_write(ea, m_y);
      // Integer add, SBC adds the complement; V from the signed range
      cpu_pkg::OP_ADC_ABS, cpu_pkg::OP_SBC_ABS: begin
        b     = (op == cpu_pkg::OP_SBC_ABS) ? ~val : val;
        u_sum = int'(m_a) + int'(b) + int'(m_p[cpu_pkg::STAT_C]);
        s_sum = int'($signed(m_a)) + int'($signed(b)) + int'(m_p[cpu_pkg::STAT_C]);
        m_p[cpu_pkg::STAT_V] = (s_sum > 127) || (s_sum < -128);
        m_p[cpu_pkg::STAT_C] = (u_sum > 255);
        m_a = u_sum[7:0];
        set_nz(m_a);
      end
      cpu_pkg::OP_AND_ABS: begin
        m_a = m_a & val;
        set_nz(m_a);
      end
      cpu_pkg::OP_ORA_ABS: begin
        m_a = m_a | val;
        set_nz(m_a);
      end
      cpu_pkg::OP_EOR_ABS: begin
        m_a = m_a ^ val;
        set_nz(m_a);
      end
      default: ;
    endcase
    // Instruction length and cycle count
    case (op)
      cpu_pkg::OP_CLC, cpu_pkg::OP_SEC, cpu_pkg::OP_CLV, cpu_pkg::OP_NOP: begin
        pc_build  = pc_build + 16'd1;
        cyc_build = cyc_build + 2;
      end
      cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDX_IMM, cpu_pkg::OP_LDY_IMM: begin
        pc_build  = pc_build + 16'd2;
        cyc_build = cyc_build + 2;
      end
      cpu_pkg::OP_JMP_ABS: begin
        pc_build  = ea;
        cyc_build = cyc_build + 3;
      end
      default: begin
        pc_build  = pc_build + 16'd3;
        cyc_build = cyc_build + 4;
      end
    endcase
  endtask

  // Bytes past the instruction end are overwritten by the next one
  task automatic emit(input cpu_pkg::opcode_e op, input cpu_pkg::addr_t opnd);
    mem[pc_build]         = op;
    mem[pc_build + 16'd1] = opnd[7:0];
    mem[pc_build + 16'd2] = opnd[15:8];
    n_instr++;
    model_exec(op, opnd);
  endtask

  task automatic build_program();
    cpu_pkg::opcode_e op;
    cpu_pkg::addr_t   opnd;
    int               idx;
    for (int i = 0; i < 65536; i++) begin
      mem[16'(i)] = i[15:8] ^ i[7:0] ^ 8'h5A;
    end
    // Operand data for absolute reads
    for (int i = 0; i < 256; i++) begin
      mem[16'h0200 + 16'(i)] = 8'($urandom);
    end
    mem[cpu_pkg::RESET_VEC_LO] = PROG_BASE[7:0];
    mem[cpu_pkg::RESET_VEC_HI] = PROG_BASE[15:8];
    pc_build  = PROG_BASE;
    cyc_build = 2;
    for (int i = 0; i < N_RANDOM; i++) begin
      idx  = int'($urandom % 19);
      op   = op_table[idx];
      opnd = 16'($urandom);
      if (op inside {cpu_pkg::OP_STA_ABS, cpu_pkg::OP_STX_ABS, cpu_pkg::OP_STY_ABS}) begin
        opnd[15:8] = 8'h03;
      end else if (op == cpu_pkg::OP_JMP_ABS) begin
        opnd = pc_build + 16'd3;
      end else begin
        opnd[15:8] = 8'h02;
      end
      emit(op, opnd);
    end
    // Final registers, then carry exposed as 0 + M + C
    emit(cpu_pkg::OP_STA_ABS, 16'h03F0);
    emit(cpu_pkg::OP_STX_ABS, 16'h03F1);
    emit(cpu_pkg::OP_STY_ABS, 16'h03F2);
    emit(cpu_pkg::OP_LDA_IMM, 16'h0000);
    emit(cpu_pkg::OP_ADC_ABS, 16'h0280);
    emit(cpu_pkg::OP_STA_ABS, 16'h03F3);
    mem[pc_build] = BAD_OP;
    bad_pc   = pc_build;
    halt_cyc = cyc_build;
    fetch_addr_q.push_back(pc_build);
    fetch_cyc_q.push_back(cyc_build);
  endtask

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_fetch(input cpu_pkg::addr_t exp);
    if (address !== exp) begin
      fetch_errs++;
      $display("FAIL %0t: bus address %h, expected %h", $time, address, exp);
    end
  endtask

  task automatic check_write(input cpu_pkg::addr_t exp_addr, input cpu_pkg::data_t exp_data);
    if (wr_enable !== 1'b1 || address !== exp_addr || wr_data !== exp_data) begin
      write_errs++;
      $display("FAIL %0t: write en %b %h <- %h, expected %h <- %h", $time,
               wr_enable, address, wr_data, exp_addr, exp_data);
    end
  endtask

  task automatic check_flags(input cpu_pkg::data_t exp);
    cpu_pkg::data_t got;
    got = cpu_top_inst.cpu_datapath_inst.p_reg;
    if (got !== exp) begin
      flag_errs++;
      $display("FAIL %0t: status %h, expected %h", $time, got, exp);
    end
  endtask

  // ----------------------------------------
  // Run
  // ----------------------------------------
  initial begin
    void'($urandom(32'h3c52));
    build_program();
    limit = 4 * (n_instr + 1) + 100;

    @(negedge clk);
    while (!resetn) begin
      check_fetch(cpu_pkg::RESET_VEC_LO);
      if (wr_enable !== 1'b0) begin
        other_errs++;
        $display("FAIL %0t: write strobe high during reset", $time);
      end
      @(negedge clk);
    end
    // Vector read in the first two cycles after release
    check_fetch(cpu_pkg::RESET_VEC_LO);
    @(negedge clk);
    check_fetch(cpu_pkg::RESET_VEC_HI);
    cyc = 1;

    while (!done) begin
      @(negedge clk);
      cyc++;
      if (fi < fetch_addr_q.size() && cyc == fetch_cyc_q[fi]) begin
        check_fetch(fetch_addr_q[fi]);
        fi++;
      end
      if (wi < wr_addr_q.size() && cyc == wr_cyc_q[wi]) begin
        check_write(wr_addr_q[wi], wr_data_q[wi]);
        wi++;
      end else if (wr_enable !== 1'b0) begin
        other_errs++;
        $display("FAIL %0t: unexpected write to %h", $time, address);
      end
      // Halted core parks on the byte after the bad opcode
      if (cyc > halt_cyc) begin
        check_fetch(bad_pc + 16'd1);
      end
      if (cyc >= halt_cyc + HOLD_CYC) begin
        done = 1'b1;
      end
      if (cyc >= limit) begin
        timed_out = 1'b1;
        done      = 1'b1;
      end
    end

    if (timed_out) begin
      $display("timeout, the core did not halt within %0d cycles", limit);
    end else begin
      check_flags(m_p);
    end
    $display("errors: fetch %0d, write %0d, flags %0d, other %0d",
             fetch_errs, write_errs, flag_errs, other_errs);
    if (!timed_out && fetch_errs + write_errs + flag_errs + other_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- testbench/tb_clock.sv
// Free-running 8 ns clock from time zero; resetn is low for the first 10 rising edges
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic resetn
);

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

  // Release lands on a rising edge
  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    resetn <= 1'b1;
  end

endmodule

//--- hdl/cpu_top.sv
// Core top level; memory must answer rd_data combinationally within the same cycle, no wait states
`timescale 1ns/1ps

module cpu_top (
  input  logic           clk,
  input  logic           resetn,
  input  cpu_pkg::data_t rd_data,
  output cpu_pkg::addr_t address,
  output cpu_pkg::data_t wr_data,
  output logic           wr_enable
);

  cpu_pkg::data_t ir;

  cpu_ctrl_if ctrl_if ();

  // Control path
  cpu_sequencer cpu_sequencer_inst (
    .clk    (clk),
    .resetn (resetn),
    .ir     (ir),
    .ctrl   (ctrl_if.seq)
  );

  // Registers, ALU and bus
  cpu_datapath cpu_datapath_inst (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .ctrl      (ctrl_if.dp),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable),
    .ir        (ir)
  );

endmodule

//--- hdl/cpu_datapath.sv
// Register file, PC and bus mux; address and write outputs are combinational from registers and rd_data
`timescale 1ns/1ps

module cpu_datapath (
  input  logic           clk,
  input  logic           resetn,
  input  cpu_pkg::data_t rd_data,
  cpu_ctrl_if.dp         ctrl,
  output cpu_pkg::addr_t address,
  output cpu_pkg::data_t wr_data,
  output logic           wr_enable,
  output cpu_pkg::data_t ir
);

  cpu_pkg::data_t acc;
  cpu_pkg::data_t x_reg;
  cpu_pkg::data_t y_reg;
  cpu_pkg::data_t p_reg;
  cpu_pkg::data_t p_next;
  cpu_pkg::addr_t pc;
  cpu_pkg::data_t opl;
  cpu_pkg::data_t oph;
  cpu_pkg::addr_t opnd_addr;

  cpu_pkg::data_t alu_result;
  logic           alu_carry;
  logic           alu_ovf;
  logic           alu_neg;
  logic           alu_zero;

  cpu_alu cpu_alu_inst (
    .op        (ctrl.alu_op),
    .a         (acc),
    .b         (rd_data),
    .carry_in  (p_reg[cpu_pkg::STAT_C]),
    .result    (alu_result),
    .carry_out (alu_carry),
    .overflow  (alu_ovf),
    .negative  (alu_neg),
    .zero      (alu_zero)
  );

  // ----------------------------------------
  // Bus side
  // ----------------------------------------
  // High operand byte is still on rd_data during OPER2
  assign opnd_addr = ctrl.oph_load ? {rd_data, opl} : {oph, opl};

  always_comb begin
    case (ctrl.addr_sel)
      cpu_pkg::ASEL_VEC: begin
        address = ctrl.pc_load_vec_hi ? cpu_pkg::RESET_VEC_HI : cpu_pkg::RESET_VEC_LO;
      end
      cpu_pkg::ASEL_OPER: address = opnd_addr;
      default:            address = pc;
    endcase
  end

  always_comb begin
    case (ctrl.target)
      cpu_pkg::REG_X: wr_data = x_reg;
      cpu_pkg::REG_Y: wr_data = y_reg;
      default:        wr_data = acc;
    endcase
  end

  assign wr_enable = ctrl.mem_write;

  // ----------------------------------------
  // PC, IR and operand bytes
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (ctrl.pc_load_vec_lo) begin
      pc[7:0] <= rd_data;
    end else if (ctrl.pc_load_vec_hi) begin
      pc[15:8] <= rd_data;
    end else if (ctrl.pc_jump) begin
      pc <= opnd_addr;
    end else if (ctrl.pc_inc) begin
      pc <= pc + 16'd1;
    end

    if (ctrl.ir_load) begin
      ir <= rd_data;
    end
    if (ctrl.opl_load) begin
      opl <= rd_data;
    end
    if (ctrl.oph_load) begin
      oph <= rd_data;
    end
  end

  // ----------------------------------------
  // Status and register file
  // ----------------------------------------
  always_comb begin
    p_next = p_reg;
    if (ctrl.flag_nz_load) begin
      p_next[cpu_pkg::STAT_N] = alu_neg;
      p_next[cpu_pkg::STAT_Z] = alu_zero;
    end
    if (ctrl.flag_cv_load) begin
      p_next[cpu_pkg::STAT_C] = alu_carry;
      p_next[cpu_pkg::STAT_V] = alu_ovf;
    end
    case (ctrl.flag_set_clear)
      cpu_pkg::OP_CLC: p_next[cpu_pkg::STAT_C] = 1'b0;
      cpu_pkg::OP_SEC: p_next[cpu_pkg::STAT_C] = 1'b1;
      cpu_pkg::OP_CLV: p_next[cpu_pkg::STAT_V] = 1'b0;
      default: ;
    endcase
    p_next[cpu_pkg::STAT_U] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      acc   <= '0;
      x_reg <= '0;
      y_reg <= '0;
      p_reg <= cpu_pkg::P_RESET;
    end else begin
      p_reg <= p_next;
      if (ctrl.reg_write) begin
        case (ctrl.target)
          cpu_pkg::REG_A: acc   <= alu_result;
          cpu_pkg::REG_X: x_reg <= alu_result;
          cpu_pkg::REG_Y: y_reg <= alu_result;
          default: ;
        endcase
      end
    end
  end

  a_p_unused_set: assert property (@(posedge clk) disable iff (!resetn)
    p_reg[cpu_pkg::STAT_U]);

endmodule

//--- hdl/cpu_sequencer.sv
// Fixed-length instruction FSM; decodes IR in OPER1, so an unknown opcode halts one cycle after fetch
`timescale 1ns/1ps

module cpu_sequencer (
  input  logic           clk,
  input  logic           resetn,
  input  cpu_pkg::data_t ir,
  cpu_ctrl_if.seq        ctrl
);

  cpu_pkg::cpu_state_e state;
  cpu_pkg::cpu_state_e state_next;
  cpu_pkg::addr_mode_e mode;
  cpu_pkg::alu_op_e    dec_alu_op;
  cpu_pkg::reg_sel_e   dec_target;

  cpu_decoder cpu_decoder_inst (
    .ir     (ir),
    .mode   (mode),
    .alu_op (dec_alu_op),
    .target (dec_target)
  );

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= cpu_pkg::ST_VEC_LO;
    end else begin
      state <= state_next;
    end
  end

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      cpu_pkg::ST_VEC_LO: state_next = cpu_pkg::ST_VEC_HI;
      cpu_pkg::ST_VEC_HI: state_next = cpu_pkg::ST_FETCH;
      cpu_pkg::ST_FETCH:  state_next = cpu_pkg::ST_OPER1;
      cpu_pkg::ST_OPER1: begin
        case (mode)
          cpu_pkg::MODE_IMP,
          cpu_pkg::MODE_IMM: state_next = cpu_pkg::ST_FETCH;
          cpu_pkg::MODE_BAD: state_next = cpu_pkg::ST_HALT;
          default:           state_next = cpu_pkg::ST_OPER2;
        endcase
      end
      cpu_pkg::ST_OPER2: begin
        state_next = (mode == cpu_pkg::MODE_JMP) ? cpu_pkg::ST_FETCH : cpu_pkg::ST_MEM;
      end
      cpu_pkg::ST_MEM:    state_next = cpu_pkg::ST_FETCH;
      default:            state_next = cpu_pkg::ST_HALT;
    endcase
  end

  // ----------------------------------------
  // Command issue
  // ----------------------------------------
  assign ctrl.target = dec_target;
  assign ctrl.alu_op = dec_alu_op;

  always_comb begin
    ctrl.addr_sel       = cpu_pkg::ASEL_PC;
    ctrl.ir_load        = 1'b0;
    ctrl.pc_load_vec_lo = 1'b0;
    ctrl.pc_load_vec_hi = 1'b0;
    ctrl.opl_load       = 1'b0;
    ctrl.oph_load       = 1'b0;
    ctrl.pc_jump        = 1'b0;
    ctrl.pc_inc         = 1'b0;
    ctrl.reg_write      = 1'b0;
    ctrl.flag_nz_load   = 1'b0;
    ctrl.flag_cv_load   = 1'b0;
    ctrl.flag_set_clear = cpu_pkg::OP_NOP;
    ctrl.mem_write      = 1'b0;

    case (state)
      cpu_pkg::ST_VEC_LO: begin
        ctrl.addr_sel       = cpu_pkg::ASEL_VEC;
        ctrl.pc_load_vec_lo = 1'b1;
      end
      cpu_pkg::ST_VEC_HI: begin
        ctrl.addr_sel       = cpu_pkg::ASEL_VEC;
        ctrl.pc_load_vec_hi = 1'b1;
      end
      cpu_pkg::ST_FETCH: begin
        ctrl.ir_load = 1'b1;
        ctrl.pc_inc  = 1'b1;
      end
      cpu_pkg::ST_OPER1: begin
        case (mode)
          // Implied is a dummy read, PC already at the next opcode
          cpu_pkg::MODE_IMP: ctrl.flag_set_clear = cpu_pkg::opcode_e'(ir);
          cpu_pkg::MODE_IMM: begin
            ctrl.reg_write    = 1'b1;
            ctrl.flag_nz_load = 1'b1;
            ctrl.pc_inc       = 1'b1;
          end
          cpu_pkg::MODE_BAD: ;
          default: begin
            ctrl.opl_load = 1'b1;
            ctrl.pc_inc   = 1'b1;
          end
        endcase
      end
      cpu_pkg::ST_OPER2: begin
        ctrl.oph_load = 1'b1;
        if (mode == cpu_pkg::MODE_JMP) begin
          ctrl.pc_jump = 1'b1;
        end else begin
          ctrl.pc_inc = 1'b1;
        end
      end
      cpu_pkg::ST_MEM: begin
        ctrl.addr_sel = cpu_pkg::ASEL_OPER;
        if (mode == cpu_pkg::MODE_ABS_WR) begin
          ctrl.mem_write = 1'b1;
        end else begin
          ctrl.reg_write    = 1'b1;
          ctrl.flag_nz_load = 1'b1;
          ctrl.flag_cv_load = (dec_alu_op == cpu_pkg::ALU_ADC) ||
                              (dec_alu_op == cpu_pkg::ALU_SBC);
        end
      end
      default: ;
    endcase
  end

  // State register only ever holds a defined encoding
  a_state_legal: assert property (@(posedge clk) disable iff (!resetn)
    state inside {cpu_pkg::ST_VEC_LO, cpu_pkg::ST_VEC_HI, cpu_pkg::ST_FETCH,
                  cpu_pkg::ST_OPER1, cpu_pkg::ST_OPER2, cpu_pkg::ST_MEM,
                  cpu_pkg::ST_HALT});

  // A store only ever comes out of the MEM cycle after OPER2
  a_write_in_mem: assert property (@(posedge clk) disable iff (!resetn)
    ctrl.mem_write |-> (state == cpu_pkg::ST_MEM) && ($past(state) == cpu_pkg::ST_OPER2));

endmodule

//--- hdl/cpu_alu.sv
// 8-bit binary ALU; no decimal mode, carry and overflow only meaningful for ADC and SBC
`timescale 1ns/1ps

module cpu_alu (
  input  cpu_pkg::alu_op_e op,
  input  cpu_pkg::data_t   a,
  input  cpu_pkg::data_t   b,
  input  logic             carry_in,
  output cpu_pkg::data_t   result,
  output logic             carry_out,
  output logic             overflow,
  output logic             negative,
  output logic             zero
);

  cpu_pkg::data_t addend;
  logic [8:0]     sum;

  // SBC is A + ~M + C
  assign addend = (op == cpu_pkg::ALU_SBC) ? ~b : b;
  assign sum    = {1'b0, a} + {1'b0, addend} + {8'd0, carry_in};

  always_comb begin
    case (op)
      cpu_pkg::ALU_ADC,
      cpu_pkg::ALU_SBC: result = sum[7:0];
      cpu_pkg::ALU_AND: result = a & b;
      cpu_pkg::ALU_ORA: result = a | b;
      cpu_pkg::ALU_EOR: result = a ^ b;
      default:          result = b;
    endcase
  end

  assign carry_out = sum[8];

  // Signed overflow when both inputs agree in sign and the sum does not
  assign overflow  = (a[7] == addend[7]) && (sum[7] != a[7]);

  assign negative  = result[7];
  assign zero      = (result == 8'h00);

endmodule

//--- hdl/cpu_decoder.sv
// Combinational opcode decode; any opcode outside the supported subset maps to MODE_BAD
`timescale 1ns/1ps

module cpu_decoder (
  input  cpu_pkg::data_t     ir,
  output cpu_pkg::addr_mode_e mode,
  output cpu_pkg::alu_op_e   alu_op,
  output cpu_pkg::reg_sel_e  target
);

  always_comb begin
    mode   = cpu_pkg::MODE_BAD;
    alu_op = cpu_pkg::ALU_PASS;
    target = cpu_pkg::REG_NONE;

    case (ir)
      // Implied, flags handled from the opcode itself
      cpu_pkg::OP_CLC,
      cpu_pkg::OP_SEC,
      cpu_pkg::OP_CLV,
      cpu_pkg::OP_NOP: mode = cpu_pkg::MODE_IMP;

      cpu_pkg::OP_LDA_IMM: begin
        mode   = cpu_pkg::MODE_IMM;
        target = cpu_pkg::REG_A;
      end
      cpu_pkg::OP_LDX_IMM: begin
        mode   = cpu_pkg::MODE_IMM;
        target = cpu_pkg::REG_X;
      end
      cpu_pkg::OP_LDY_IMM: begin
        mode   = cpu_pkg::MODE_IMM;
        target = cpu_pkg::REG_Y;
      end

      cpu_pkg::OP_LDA_ABS: begin
        mode   = cpu_pkg::MODE_ABS_RD;
        target = cpu_pkg::REG_A;
      end
      cpu_pkg::OP_LDX_ABS: begin
        mode   = cpu_pkg::MODE_ABS_RD;
        target = cpu_pkg::REG_X;
      end
      cpu_pkg::OP_LDY_ABS: begin
        mode   = cpu_pkg::MODE_ABS_RD;
        target = cpu_pkg::REG_Y;
      end

      // Stores, target is the source register
      cpu_pkg::OP_STA_ABS: begin
        mode   = cpu_pkg::MODE_ABS_WR;
        target = cpu_pkg::REG_A;
      end
      cpu_pkg::OP_STX_ABS: begin
        mode   = cpu_pkg::MODE_ABS_WR;
        target = cpu_pkg::REG_X;
      end
      cpu_pkg::OP_STY_ABS: begin
        mode   = cpu_pkg::MODE_ABS_WR;
        target = cpu_pkg::REG_Y;
      end

      // Accumulator arithmetic and logic
      cpu_pkg::OP_ADC_ABS,
      cpu_pkg::OP_SBC_ABS,
      cpu_pkg::OP_AND_ABS,
      cpu_pkg::OP_ORA_ABS,
      cpu_pkg::OP_EOR_ABS: begin
        mode   = cpu_pkg::MODE_ABS_RD;
        target = cpu_pkg::REG_A;
        case (ir)
          cpu_pkg::OP_ADC_ABS: alu_op = cpu_pkg::ALU_ADC;
          cpu_pkg::OP_SBC_ABS: alu_op = cpu_pkg::ALU_SBC;
          cpu_pkg::OP_AND_ABS: alu_op = cpu_pkg::ALU_AND;
          cpu_pkg::OP_ORA_ABS: alu_op = cpu_pkg::ALU_ORA;
          default:             alu_op = cpu_pkg::ALU_EOR;
        endcase
      end

      cpu_pkg::OP_JMP_ABS: mode = cpu_pkg::MODE_JMP;

      default: ;
    endcase
  end

endmodule

//--- hdl/cpu_ctrl_if.sv
// Per-cycle commands from sequencer to datapath; every command takes effect in the cycle it is issued
`timescale 1ns/1ps

interface cpu_ctrl_if;

  // Bus address select
  cpu_pkg::addr_sel_e addr_sel;

  // Register load strobes
  logic ir_load;
  logic pc_load_vec_lo;
  logic pc_load_vec_hi;
  logic opl_load;
  logic oph_load;
  logic pc_jump;
  logic pc_inc;

  // Register file write and ALU control
  logic               reg_write;
  cpu_pkg::reg_sel_e  target;
  cpu_pkg::alu_op_e   alu_op;

  // Status updates, set/clear holds OP_NOP when idle
  logic               flag_nz_load;
  logic               flag_cv_load;
  cpu_pkg::opcode_e   flag_set_clear;

  logic mem_write;

  modport seq (
    output addr_sel, ir_load, pc_load_vec_lo, pc_load_vec_hi, opl_load, oph_load,
           pc_jump, pc_inc, reg_write, target, alu_op, flag_nz_load, flag_cv_load,
           flag_set_clear, mem_write
  );

  modport dp (
    input addr_sel, ir_load, pc_load_vec_lo, pc_load_vec_hi, opl_load, oph_load,
          pc_jump, pc_inc, reg_write, target, alu_op, flag_nz_load, flag_cv_load,
          flag_set_clear, mem_write
  );

endinterface

//--- hdl/cpu_pkg.sv
// Shared types for the 6502 subset core; opcode values are the real 6502 encodings, no decimal mode
package cpu_pkg;

  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Reset vector location
  localparam addr_t RESET_VEC_LO = 16'hFFFC;
  localparam addr_t RESET_VEC_HI = 16'hFFFD;

  // Status register layout, only the unused bit set out of reset
  localparam data_t P_RESET = 8'h20;
  localparam int    STAT_C  = 0;
  localparam int    STAT_Z  = 1;
  localparam int    STAT_U  = 5;
  localparam int    STAT_V  = 6;
  localparam int    STAT_N  = 7;

  // ----------------------------------------
  // Opcodes of the supported subset
  // ----------------------------------------
  typedef enum logic [7:0] {
    OP_CLC     = 8'h18,
    OP_SEC     = 8'h38,
    OP_CLV     = 8'hB8,
    OP_NOP     = 8'hEA,
    OP_LDA_IMM = 8'hA9,
    OP_LDX_IMM = 8'hA2,
    OP_LDY_IMM = 8'hA0,
    OP_LDA_ABS = 8'hAD,
    OP_LDX_ABS = 8'hAE,
    OP_LDY_ABS = 8'hAC,
    OP_STA_ABS = 8'h8D,
    OP_STX_ABS = 8'h8E,
    OP_STY_ABS = 8'h8C,
    OP_ADC_ABS = 8'h6D,
    OP_SBC_ABS = 8'hED,
    OP_AND_ABS = 8'h2D,
    OP_ORA_ABS = 8'h0D,
    OP_EOR_ABS = 8'h4D,
    OP_JMP_ABS = 8'h4C
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADC, ALU_SBC, ALU_AND, ALU_ORA, ALU_EOR, ALU_PASS
  } alu_op_e;

  typedef enum logic [2:0] {
    MODE_IMP, MODE_IMM, MODE_ABS_RD, MODE_ABS_WR, MODE_JMP, MODE_BAD
  } addr_mode_e;

  typedef enum logic [1:0] {REG_A, REG_X, REG_Y, REG_NONE} reg_sel_e;

  typedef enum logic [2:0] {
    ST_VEC_LO, ST_VEC_HI, ST_FETCH, ST_OPER1, ST_OPER2, ST_MEM, ST_HALT
  } cpu_state_e;

  // Bus address source
  typedef enum logic [1:0] {ASEL_PC, ASEL_OPER, ASEL_VEC} addr_sel_e;

endpackage
